//--- files.f
rtl/e40_pkg.sv
rtl/status_decode.sv
rtl/packet_client.sv
rtl/optics_control.sv
rtl/status_read_combine.sv
rtl/e40_tx_top.sv
verification/tb_clock_gen.sv
verification/e40_tx_checker.sv
verification/e40_tx_tb.sv

//--- Bender.yml
package:
  name: e40_tx

sources:
  # design
  - rtl/e40_pkg.sv
  - rtl/status_decode.sv
  - rtl/packet_client.sv
  - rtl/optics_control.sv
  - rtl/status_read_combine.sv
  - rtl/e40_tx_top.sv

  # testbench
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/e40_tx_checker.sv
      - verification/e40_tx_tb.sv

//--- verification/e40_tx_tb.sv
`timescale 1ns/1ps

module e40_tx_tb;

	logic                       clk_status;
	logic                       rst_n;
	logic                       psel;
	logic                       penable;
	logic                       pwrite;
	logic [e40_pkg::addr_w-1:0] paddr;
	logic [e40_pkg::reg_w-1:0]  pwdata;
	logic                       pready;
	logic [e40_pkg::reg_w-1:0]  prdata;
	logic                       pslverr;
	logic [e40_pkg::data_w-1:0] din;
	logic [e40_pkg::words-1:0]  din_start;
	logic [e40_pkg::end_w-1:0]  din_end_pos;
	logic                       din_ack;
	logic                       cfp_mod_abs;
	logic                       cfp_rx_los;
	logic                       cfp_glb_alrm;
	logic [3:1]                 cfp_prg_alrm;
	logic                       cfp_mod_lopwr;
	logic                       cfp_mod_rst;
	logic                       cfp_tx_dis;
	logic [3:1]                 cfp_prg_cntl;
	logic [4:0]                 cfp_prtadr;

	string       test_name;
	logic [31:0] ack_rnd;
	logic [31:0] len_rnd;
	int          run_len [6];   // six packet runs
	int          run_cnt [6];
	int          limit_cycles;
	int          exp_len;       // programmed length of the current run
	int          pkt_num;       // packets seen in the current run
	int          byte_idx;
	logic        in_pkt;
	logic [31:0] rd;
	logic        err;

	tb_clock_gen clock_inst (.clk_status(clk_status), .rst_n(rst_n));

	e40_tx_top e40_tx_top_inst (.*);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// pins packed in control register order
	function automatic logic [31:0] cfp_pins();
		return {21'b0, cfp_prtadr, cfp_prg_cntl, cfp_tx_dis, cfp_mod_rst, cfp_mod_lopwr};
	endfunction

	function automatic logic [31:0] alarm_pins();
		return {26'b0, cfp_prg_alrm, cfp_glb_alrm, cfp_rx_los, cfp_mod_abs};
	endfunction

	task automatic fail_run();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
			fail_run();
		end
	endtask

	// called and returns between falling edges
	task automatic bus_transfer(input logic wr, input logic [15:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		@(negedge clk_status);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk_status);
		penable = 1'b1;
		@(negedge clk_status);
		while (!pready) @(negedge clk_status);   // watchdog bounds this
		rdata  = prdata;
		slverr = pslverr;
		@(negedge clk_status);                   // hold through the ready edge
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic        e;
		bus_transfer(1'b1, addr, data, unused, e);
		check_value("write slverr", 0, e);
	endtask

	task automatic expect_reg(input string what, input logic [15:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		logic        e;
		bus_transfer(1'b0, addr, 0, data, e);
		check_value("read slverr", 0, e);
		check_value(what, exp, data);
	endtask

	////////////////////////////////////////
	// tx side
	////////////////////////////////////////

	// about three quarters of the cycles accept
	initial begin : ack_driver
		din_ack = 1'b0;
		ack_rnd = 32'h0178253f;
		forever begin
			@(negedge clk_status);
			ack_rnd = xorshift(ack_rnd);
			din_ack = (ack_rnd[1:0] != 2'b00);
		end
	end

	// rebuild packets from accepted beats, lane 0 in the top byte
	always @(posedge clk_status) begin : stream_monitor
		logic [7:0] b;
		logic       ended;
		logic       end_bit;
		if (rst_n && din_ack) begin
			if (din_start != '0) begin
				check_value("start lane", 32'h2, din_start);
				check_value("start inside packet", 0, in_pkt);
				in_pkt   = 1'b1;
				byte_idx = 0;
			end
			ended = 1'b0;
			for (int i = 0; i < e40_pkg::end_w; i++) begin
				b       = din[e40_pkg::data_w-1-8*i -: 8];
				end_bit = din_end_pos[e40_pkg::end_w-1-i];
				if (!in_pkt || ended) begin
					check_value("byte outside packet", 0, {end_bit, b});
				end else begin
					check_value("payload byte", (pkt_num + byte_idx) % 256, b);
					byte_idx++;
					if (end_bit) begin
						ended = 1'b1;
						check_value("packet length", exp_len, byte_idx);
					end
				end
			end
			if (ended) begin
				pkt_num++;
				in_pkt = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// watchdogs
	////////////////////////////////////////

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_status);
		$display("Timeout: tests did not finish within %0d cycles", limit_cycles);
		fail_run();
	end

	always @(e40_tx_top_inst.checker_inst.fail_cnt) begin
		if (e40_tx_top_inst.checker_inst.fail_cnt != 0) begin
			$display("A bound assertion on the DUT failed");
			fail_run();
		end
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin : main
		int beats;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		cfp_mod_abs  = 1'b0;
		cfp_rx_los   = 1'b0;
		cfp_glb_alrm = 1'b0;
		cfp_prg_alrm = 3'b000;
		in_pkt       = 1'b0;
		pkt_num      = 0;
		exp_len      = 0;
		limit_cycles = 0;

		// runs 0 and 1 hit the length limits, the rest are random
		len_rnd = 32'h0178253f;
		beats   = 0;
		for (int r = 0; r < 6; r++) begin
			len_rnd    = xorshift(len_rnd);
			run_len[r] = e40_pkg::min_len + len_rnd % (e40_pkg::max_len - e40_pkg::min_len + 1);
			if (r == 0) run_len[r] = e40_pkg::min_len;
			if (r == 1) run_len[r] = e40_pkg::max_len;
			len_rnd    = xorshift(len_rnd);
			run_cnt[r] = 1 + len_rnd % 4;
			beats      = beats + run_cnt[r] * ((run_len[r] + 15) / 16);
		end
		limit_cycles = beats * 4 + (40 + 6 * 5) * 8 + 100;   // stream plus bus traffic

		wait (rst_n === 1'b1);

		test_name = "reset values";
		check_value("cfp pins", e40_pkg::opt_ctrl_rst, cfp_pins());
		check_value("stream ones", 0, $countones({din, din_start, din_end_pos}));
		expect_reg("opt_ctrl", {e40_pkg::sel_optics, e40_pkg::opt_ctrl}, e40_pkg::opt_ctrl_rst);

		test_name = "control writes";
		write_reg({e40_pkg::sel_optics, e40_pkg::opt_ctrl}, 32'h0000_05aa);
		check_value("cfp pins", 32'h0000_05aa, cfp_pins());
		expect_reg("opt_ctrl", {e40_pkg::sel_optics, e40_pkg::opt_ctrl}, 32'h0000_05aa);

		test_name = "sticky alarms";
		cfp_mod_abs  = 1'b1;
		cfp_rx_los   = 1'b1;
		cfp_glb_alrm = 1'b1;
		cfp_prg_alrm = 3'b101;
		repeat (4) @(negedge clk_status);   // two sync flops and the edge flop
		expect_reg("live status", {e40_pkg::sel_optics, e40_pkg::opt_status}, alarm_pins());
		cfp_rx_los   = 1'b0;
		cfp_glb_alrm = 1'b0;
		cfp_prg_alrm = 3'b000;
		repeat (4) @(negedge clk_status);
		expect_reg("live status", {e40_pkg::sel_optics, e40_pkg::opt_status}, alarm_pins());
		// every alarm rose once, mod_abs never latches
		expect_reg("sticky", {e40_pkg::sel_optics, e40_pkg::opt_sticky}, 32'h2e);
		write_reg({e40_pkg::sel_optics, e40_pkg::opt_sticky}, 32'h02);
		expect_reg("sticky after rx_los clear", {e40_pkg::sel_optics, e40_pkg::opt_sticky}, 32'h2c);
		write_reg({e40_pkg::sel_optics, e40_pkg::opt_sticky}, 32'h2c);
		expect_reg("sticky all clear", {e40_pkg::sel_optics, e40_pkg::opt_sticky}, 32'h00);

		test_name = "length clamping";
		write_reg({e40_pkg::sel_pc, e40_pkg::pc_len}, 32'd3);
		expect_reg("short length", {e40_pkg::sel_pc, e40_pkg::pc_len}, e40_pkg::min_len);
		write_reg({e40_pkg::sel_pc, e40_pkg::pc_len}, 32'd5000);
		expect_reg("long length", {e40_pkg::sel_pc, e40_pkg::pc_len}, e40_pkg::max_len);

		test_name = "unmapped address";
		bus_transfer(1'b1, 16'h2000, 32'hffff_ffff, rd, err);
		check_value("write slverr", 1, err);
		// offset 4 would land on pc_len
		bus_transfer(1'b1, 16'h2004, 32'h0000_0010, rd, err);
		check_value("write slverr", 1, err);
		bus_transfer(1'b0, 16'h2004, 32'h0, rd, err);
		check_value("read slverr", 1, err);
		check_value("read data", 0, rd);
		expect_reg("opt_ctrl kept", {e40_pkg::sel_optics, e40_pkg::opt_ctrl}, 32'h0000_05aa);
		expect_reg("pc_len kept", {e40_pkg::sel_pc, e40_pkg::pc_len}, e40_pkg::max_len);

		test_name = "packet stream";
		for (int r = 0; r < 6; r++) begin
			exp_len = run_len[r];
			pkt_num = 0;                    // payload numbering restarts per run
			write_reg({e40_pkg::sel_pc, e40_pkg::pc_len}, run_len[r]);
			write_reg({e40_pkg::sel_pc, e40_pkg::pc_count}, run_cnt[r]);
			write_reg({e40_pkg::sel_pc, e40_pkg::pc_ctrl}, 32'h1);
			while (pkt_num < run_cnt[r]) @(negedge clk_status);
			expect_reg("pc_sent", {e40_pkg::sel_pc, e40_pkg::pc_sent}, run_cnt[r]);
			expect_reg("run bit", {e40_pkg::sel_pc, e40_pkg::pc_ctrl}, 32'h0);
			check_value("packets seen", run_cnt[r], pkt_num);
		end

		if (e40_tx_top_inst.checker_inst.fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

//--- verification/e40_tx_checker.sv
`timescale 1ns/1ps

module e40_tx_checker (
	input logic                       clk_status,
	input logic                       rst_n,
	input logic                       psel,
	input logic                       penable,
	input logic [e40_pkg::addr_w-1:0] paddr,
	input logic                       pready,
	input logic                       pslverr,
	input logic [e40_pkg::data_w-1:0] din,
	input logic [e40_pkg::words-1:0]  din_start,
	input logic [e40_pkg::end_w-1:0]  din_end_pos,
	input logic                       din_ack
);

	int   fail_cnt;   // read by the testbench
	logic beat;       // something on the wire
	logic unmapped;   // select with no block behind it

	logic [e40_pkg::end_w-1:0]  after_end;   // byte flags past the end flag
	logic [e40_pkg::data_w-1:0] tail_mask;   // same, one bit per data bit

	initial fail_cnt = 0;

	// 16 consecutive payload bytes are never all zero, so zero means idle
	assign beat = (din != '0) || (din_start != '0) || (din_end_pos != '0);

	assign unmapped = (paddr[e40_pkg::addr_w-1 -: 4] != e40_pkg::sel_pc) &&
		(paddr[e40_pkg::addr_w-1 -: 4] != e40_pkg::sel_optics);

	// end flag bit j marks the byte in din[8*j +: 8]
	assign after_end = (din_end_pos != '0) ? din_end_pos - 1'b1 : '0;

	always_comb begin
		for (int i = 0; i < e40_pkg::end_w; i++) begin
			tail_mask[8*i +: 8] = {8{after_end[i]}};
		end
	end

	////////////////////////////////////////
	// tx stream
	////////////////////////////////////////

	hold_beat: assert property (@(posedge clk_status) disable iff (!rst_n)
		beat && !din_ack |=> $stable(din) && $stable(din_start) && $stable(din_end_pos))
	else begin
		$error("tx beat changed while waiting for din_ack");
		fail_cnt++;
	end

	// one end flag at most, nothing but zero bytes behind it
	end_onehot: assert property (@(posedge clk_status) disable iff (!rst_n)
		$onehot0(din_end_pos) && ((din & tail_mask) == '0))
	else begin
		$error("din_end_pos not one-hot, or bytes past the end not zero");
		fail_cnt++;
	end

	////////////////////////////////////////
	// apb response
	////////////////////////////////////////

	// setup, one waiting access cycle, then ready
	ready_timing: assert property (@(posedge clk_status) disable iff (!rst_n)
		psel && !penable |=> (penable && !pready) ##1 (penable && pready))
	else begin
		$error("pready not in the second access cycle");
		fail_cnt++;
	end

	err_with_ready: assert property (@(posedge clk_status) disable iff (!rst_n)
		pslverr |-> pready && psel && penable && unmapped)
	else begin
		$error("pslverr outside the completion of an unmapped access");
		fail_cnt++;
	end

endmodule

bind e40_tx_top e40_tx_checker checker_inst (
	.clk_status  (clk_status),
	.rst_n       (rst_n),
	.psel        (psel),
	.penable     (penable),
	.paddr       (paddr),
	.pready      (pready),
	.pslverr     (pslverr),
	.din         (din),
	.din_start   (din_start),
	.din_end_pos (din_end_pos),
	.din_ack     (din_ack)
);

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_status,
	output logic rst_n
);

	// 10 ns period, first rising edge at 5 ns
	initial begin
		clk_status = 1'b0;
		forever #5 clk_status = ~clk_status;
	end

	// low across the first two rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (2) @(negedge clk_status);
		rst_n = 1'b1;
	end

endmodule

//--- rtl/e40_tx_top.sv
`timescale 1ns/1ps

module e40_tx_top (
	input  logic                       clk_status,
	input  logic                       rst_n,

	// apb status bus
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [e40_pkg::addr_w-1:0] paddr,
	input  logic [e40_pkg::reg_w-1:0]  pwdata,
	output logic                       pready,
	output logic [e40_pkg::reg_w-1:0]  prdata,
	output logic                       pslverr,

	// tx stream toward the mac
	output logic [e40_pkg::data_w-1:0] din,          // regular left to right
	output logic [e40_pkg::words-1:0]  din_start,
	output logic [e40_pkg::end_w-1:0]  din_end_pos,  // last byte, any position
	input  logic                       din_ack,

	// cfp pins
	input  logic                       cfp_mod_abs,
	input  logic                       cfp_rx_los,
	input  logic                       cfp_glb_alrm,
	input  logic [3:1]                 cfp_prg_alrm,
	output logic                       cfp_mod_lopwr,
	output logic                       cfp_mod_rst,  // active low
	output logic                       cfp_tx_dis,
	output logic [3:1]                 cfp_prg_cntl,
	output logic [4:0]                 cfp_prtadr
);

	logic [11:0]               reg_addr;
	logic [e40_pkg::reg_w-1:0] reg_wdata;
	logic                      pc_read;
	logic                      pc_write;
	logic                      opt_read;
	logic                      opt_write;
	logic                      miss;
	logic                      pc_done;
	logic [e40_pkg::reg_w-1:0] pc_rdata;
	logic                      opt_done;
	logic [e40_pkg::reg_w-1:0] opt_rdata;

	////////////////////////////////////////
	// bus front end
	////////////////////////////////////////

	status_decode decode_inst (
		.clk_status (clk_status),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.pready     (pready),     // ends the busy window
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.pc_read    (pc_read),
		.pc_write   (pc_write),
		.opt_read   (opt_read),
		.opt_write  (opt_write),
		.miss       (miss)
	);

	////////////////////////////////////////
	// packet generator
	////////////////////////////////////////

	packet_client pc_inst (
		.clk_status  (clk_status),
		.rst_n       (rst_n),
		.reg_read    (pc_read),
		.reg_write   (pc_write),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.din_ack     (din_ack),
		.done        (pc_done),
		.rdata       (pc_rdata),
		.din         (din),
		.din_start   (din_start),
		.din_end_pos (din_end_pos)
	);

	////////////////////////////////////////
	// cfp control
	////////////////////////////////////////

	optics_control optics_inst (
		.clk_status    (clk_status),
		.rst_n         (rst_n),
		.reg_read      (opt_read),
		.reg_write     (opt_write),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.cfp_mod_abs   (cfp_mod_abs),
		.cfp_rx_los    (cfp_rx_los),
		.cfp_glb_alrm  (cfp_glb_alrm),
		.cfp_prg_alrm  (cfp_prg_alrm),
		.done          (opt_done),
		.rdata         (opt_rdata),
		.cfp_mod_lopwr (cfp_mod_lopwr),
		.cfp_mod_rst   (cfp_mod_rst),
		.cfp_tx_dis    (cfp_tx_dis),
		.cfp_prg_cntl  (cfp_prg_cntl),
		.cfp_prtadr    (cfp_prtadr)
	);

	////////////////////////////////////////
	// merge replies
	////////////////////////////////////////

	status_read_combine combine_inst (
		.clk_status (clk_status),
		.rst_n      (rst_n),
		.miss       (miss),
		.pc_done    (pc_done),
		.pc_rdata   (pc_rdata),
		.opt_done   (opt_done),
		.opt_rdata  (opt_rdata),
		.pready     (pready),
		.prdata     (prdata),
		.pslverr    (pslverr)
	);

endmodule

//--- rtl/status_read_combine.sv
`timescale 1ns/1ps

module status_read_combine (
	input  logic                      clk_status,
	input  logic                      rst_n,
	input  logic                      miss,
	input  logic                      pc_done,
	input  logic [e40_pkg::reg_w-1:0] pc_rdata,
	input  logic                      opt_done,
	input  logic [e40_pkg::reg_w-1:0] opt_rdata,
	output logic                      pready,
	output logic [e40_pkg::reg_w-1:0] prdata,
	output logic                      pslverr
);

	logic miss_q;   // lines up with client done

	////////////////////////////////////////
	// unmapped access
	////////////////////////////////////////

	// nobody answers a miss, so answer it here one cycle late
	always_ff @(posedge clk_status) begin
		if (!rst_n) begin
			miss_q <= 1'b0;
		end else begin
			miss_q <= miss;
		end
	end

	////////////////////////////////////////
	// merge
	////////////////////////////////////////

	// at most one done per transfer
	assign pready = pc_done | opt_done | miss_q;

	// idle clients hold zero, plain or is enough
	assign prdata = pc_rdata | opt_rdata;

	assign pslverr = miss_q;   // only ever with pready

endmodule

//--- rtl/optics_control.sv
`timescale 1ns/1ps

module optics_control (
	input  logic                      clk_status,
	input  logic                      rst_n,
	input  logic                      reg_read,
	input  logic                      reg_write,
	input  logic [11:0]               reg_addr,
	input  logic [e40_pkg::reg_w-1:0] reg_wdata,
	input  logic                      cfp_mod_abs,
	input  logic                      cfp_rx_los,
	input  logic                      cfp_glb_alrm,
	input  logic [3:1]                cfp_prg_alrm,
	output logic                      done,
	output logic [e40_pkg::reg_w-1:0] rdata,
	output logic                      cfp_mod_lopwr,
	output logic                      cfp_mod_rst,
	output logic                      cfp_tx_dis,
	output logic [3:1]                cfp_prg_cntl,
	output logic [4:0]                cfp_prtadr
);

	logic [e40_pkg::ctl_w-1:0] ctrl_q;
	logic [e40_pkg::st_w-1:0]  in_raw;
	logic [e40_pkg::st_w-1:0]  in_meta;   // first sync stage
	logic [e40_pkg::st_w-1:0]  in_sync;
	logic [e40_pkg::st_w-1:0]  in_prev;   // for edge detect
	logic [e40_pkg::st_w-1:0]  rise;
	logic [e40_pkg::st_w-1:0]  clr;
	logic [e40_pkg::st_w-1:0]  sticky_q;

	////////////////////////////////////////
	// cfp pins
	////////////////////////////////////////

	assign cfp_mod_lopwr = ctrl_q[e40_pkg::ctl_lopwr];
	assign cfp_mod_rst   = ctrl_q[e40_pkg::ctl_mod_rst];  // active low at the module
	assign cfp_tx_dis    = ctrl_q[e40_pkg::ctl_tx_dis];
	assign cfp_prg_cntl  = ctrl_q[e40_pkg::ctl_prg_cntl +: 3];
	assign cfp_prtadr    = ctrl_q[e40_pkg::ctl_prtadr +: 5];

	always_ff @(posedge clk_status) begin
		if (!rst_n) begin
			ctrl_q <= e40_pkg::opt_ctrl_rst[e40_pkg::ctl_w-1:0];
		end else if (reg_write && (reg_addr == e40_pkg::opt_ctrl)) begin
			ctrl_q <= reg_wdata[e40_pkg::ctl_w-1:0];
		end
	end

	////////////////////////////////////////
	// alarm inputs
	////////////////////////////////////////

	assign in_raw = {cfp_prg_alrm, cfp_glb_alrm, cfp_rx_los, cfp_mod_abs};
	assign rise   = in_sync & ~in_prev & e40_pkg::alarm_mask;
	assign clr    = (reg_write && (reg_addr == e40_pkg::opt_sticky)) ?
		reg_wdata[e40_pkg::st_w-1:0] : '0;

	// two flop sync, pins are async to clk_status
	always_ff @(posedge clk_status) begin
		if (!rst_n) begin
			in_meta  <= '0;
			in_sync  <= '0;
			in_prev  <= '0;
			sticky_q <= '0;
		end else begin
			in_meta  <= in_raw;
			in_sync  <= in_meta;
			in_prev  <= in_sync;
			sticky_q <= (sticky_q & ~clr) | rise;  // new edge wins over clear
		end
	end

	////////////////////////////////////////
	// register reads
	////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= reg_read | reg_write;
		end
	end

	always_ff @(posedge clk_status) begin
		rdata <= '0;
		if (reg_read) begin
			case (reg_addr)
				e40_pkg::opt_ctrl:   rdata <= {{(e40_pkg::reg_w-e40_pkg::ctl_w){1'b0}}, ctrl_q};
				e40_pkg::opt_status: rdata <= {{(e40_pkg::reg_w-e40_pkg::st_w){1'b0}}, in_sync};
				e40_pkg::opt_sticky: rdata <= {{(e40_pkg::reg_w-e40_pkg::st_w){1'b0}}, sticky_q};
				default:             rdata <= '0;
			endcase
		end
	end

endmodule

//--- rtl/packet_client.sv
`timescale 1ns/1ps

module packet_client (
	input  logic                       clk_status,
	input  logic                       rst_n,
	input  logic                       reg_read,
	input  logic                       reg_write,
	input  logic [11:0]                reg_addr,
	input  logic [e40_pkg::reg_w-1:0]  reg_wdata,
	input  logic                       din_ack,
	output logic                       done,
	output logic [e40_pkg::reg_w-1:0]  rdata,
	output logic [e40_pkg::data_w-1:0] din,
	output logic [e40_pkg::words-1:0]  din_start,
	output logic [e40_pkg::end_w-1:0]  din_end_pos
);

	logic                       run_q;
	logic [e40_pkg::len_w-1:0]  len_q;
	logic [e40_pkg::reg_w-1:0]  count_q;
	logic [e40_pkg::reg_w-1:0]  sent_q;
	logic [e40_pkg::len_w-1:0]  off_q;      // byte offset of the next beat
	logic [7:0]                 pkt_q;      // packet number of the next beat
	logic                       beat_valid; // din holds a packet beat

	logic                       wr_ctrl;
	logic                       start;
	logic                       go;
	logic                       adv;
	logic                       end_acc;
	logic                       more;
	logic                       last;
	logic [e40_pkg::reg_w-1:0]  sent_nxt;
	logic [7:0]                 pkt_base;
	logic [e40_pkg::len_w:0]    off_end;
	logic [e40_pkg::len_w-1:0]  len_left;   // last byte index from off_q
	logic [e40_pkg::len_w-1:0]  len_wr;
	logic [e40_pkg::data_w-1:0] b_data;
	logic [e40_pkg::end_w-1:0]  b_end;

	////////////////////////////////////////
	// run control
	////////////////////////////////////////

	assign wr_ctrl  = reg_write && (reg_addr == e40_pkg::pc_ctrl);
	assign start    = wr_ctrl && reg_wdata[0] && !run_q && (off_q == '0); // packet boundary
	assign go       = start ? (count_q != '0) : run_q;
	assign adv      = !beat_valid || din_ack;   // output slot free
	assign end_acc  = beat_valid && din_ack && (din_end_pos != '0);
	assign sent_nxt = start ? '0 : sent_q + end_acc;
	assign more     = (off_q != '0) || (go && (sent_nxt < count_q)); // mid packet or new one
	assign pkt_base = start ? 8'd0 : pkt_q;

	// clamp on write
	always_comb begin
		if (reg_wdata < e40_pkg::min_len) begin
			len_wr = e40_pkg::len_w'(e40_pkg::min_len);
		end else if (reg_wdata > e40_pkg::max_len) begin
			len_wr = e40_pkg::len_w'(e40_pkg::max_len);
		end else begin
			len_wr = reg_wdata[e40_pkg::len_w-1:0];
		end
	end

	////////////////////////////////////////
	// beat builder
	////////////////////////////////////////

	assign off_end  = {1'b0, off_q} + (e40_pkg::len_w + 1)'(e40_pkg::end_w);
	assign last     = (off_end >= {1'b0, len_q});  // packet ends in this beat
	assign len_left = len_q - off_q - 1'b1;
	assign b_end    = last ? ({1'b1, {(e40_pkg::end_w-1){1'b0}}} >> len_left) : '0;

	// byte k of packet p is p + k, left to right, zero past the end
	always_comb begin
		b_data = '0;
		for (int i = 0; i < e40_pkg::end_w; i++) begin
			if (off_q + i < len_q) begin
				b_data[e40_pkg::data_w-1-8*i -: 8] = pkt_base + off_q[7:0] + 8'(i);
			end
		end
	end

	always_ff @(posedge clk_status) begin
		if (!rst_n) begin
			run_q       <= 1'b0;
			len_q       <= e40_pkg::len_w'(e40_pkg::min_len);
			count_q     <= '0;
			sent_q      <= '0;
			off_q       <= '0;
			pkt_q       <= '0;
			beat_valid  <= 1'b0;
			din         <= '0;
			din_start   <= '0;
			din_end_pos <= '0;
		end else begin
			sent_q <= sent_nxt;
			if (wr_ctrl && !reg_wdata[0]) begin
				run_q <= 1'b0;               // stop, current packet drains
			end else if (start) begin
				run_q <= (count_q != '0);
			end else if (run_q && (sent_nxt >= count_q)) begin
				run_q <= 1'b0;               // all packets out
			end
			if (reg_write && (reg_addr == e40_pkg::pc_len)) begin
				len_q <= len_wr;
			end
			if (reg_write && (reg_addr == e40_pkg::pc_count)) begin
				count_q <= reg_wdata;
			end
			if (adv && more) begin
				din         <= b_data;
				din_start   <= (off_q == '0) ? {1'b1, {(e40_pkg::words-1){1'b0}}} : '0;
				din_end_pos <= b_end;
				beat_valid  <= 1'b1;
				off_q       <= last ? '0 : off_end[e40_pkg::len_w-1:0];
				pkt_q       <= last ? pkt_base + 8'd1 : pkt_base;
			end else if (adv) begin
				din         <= '0;               // idle beat
				din_start   <= '0;
				din_end_pos <= '0;
				beat_valid  <= 1'b0;
				pkt_q       <= pkt_base;
			end else if (start) begin
				pkt_q <= '0;                     // end beat of old run still waiting
			end
		end
	end

	////////////////////////////////////////
	// register reads
	////////////////////////////////////////

	always_ff @(posedge clk_status) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= reg_read | reg_write;    // answer one cycle after strobe
		end
	end

	always_ff @(posedge clk_status) begin
		rdata <= '0;
		if (reg_read) begin
			case (reg_addr)
				e40_pkg::pc_ctrl:  rdata <= {{(e40_pkg::reg_w-1){1'b0}}, run_q};
				e40_pkg::pc_len:   rdata <= {{(e40_pkg::reg_w-e40_pkg::len_w){1'b0}}, len_q};
				e40_pkg::pc_count: rdata <= count_q;
				e40_pkg::pc_sent:  rdata <= sent_q;
				default:           rdata <= '0;
			endcase
		end
	end

endmodule

//--- rtl/status_decode.sv
`timescale 1ns/1ps

module status_decode (
	input  logic                       clk_status,
	input  logic                       rst_n,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [e40_pkg::addr_w-1:0] paddr,
	input  logic [e40_pkg::reg_w-1:0]  pwdata,
	input  logic                       pready,
	output logic [11:0]                reg_addr,
	output logic [e40_pkg::reg_w-1:0]  reg_wdata,
	output logic                       pc_read,
	output logic                       pc_write,
	output logic                       opt_read,
	output logic                       opt_write,
	output logic                       miss
);

	logic       busy;    // strobe out, waiting for pready
	logic       first;   // first access cycle
	logic [3:0] sel;
	logic       hit_pc;
	logic       hit_opt;

	assign sel     = paddr[e40_pkg::addr_w-1 -: 4]; // block select
	assign first   = psel & penable & ~busy;
	assign hit_pc  = (sel == e40_pkg::sel_pc);
	assign hit_opt = (sel == e40_pkg::sel_optics);

	// one strobe per transfer
	assign pc_read   = first & hit_pc & ~pwrite;
	assign pc_write  = first & hit_pc & pwrite;
	assign opt_read  = first & hit_opt & ~pwrite;
	assign opt_write = first & hit_opt & pwrite;
	assign miss      = first & ~hit_pc & ~hit_opt; // unmapped select

	// shared by both execute blocks
	assign reg_addr  = paddr[11:0];
	assign reg_wdata = pwdata;

	// busy covers the waiting access cycle
	always_ff @(posedge clk_status) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (pready) begin
			busy <= 1'b0;   // transfer done
		end else if (first) begin
			busy <= 1'b1;
		end
	end

endmodule

//--- rtl/e40_pkg.sv
package e40_pkg;

	////////////////////////////////////////
	// tx stream geometry
	////////////////////////////////////////

	localparam int words  = 2;           // 64-bit lanes per beat
	localparam int data_w = words * 64;  // din, lane 0 in the top word
	localparam int end_w  = words * 8;   // one end flag per byte

	// packet length limits, bytes
	localparam int min_len = 9;
	localparam int max_len = 1518;
	localparam int len_w   = 11;         // wide enough for max_len

	////////////////////////////////////////
	// status bus
	////////////////////////////////////////

	localparam int addr_w = 16;
	localparam int reg_w  = 32;

	// block select, paddr[15:12]
	localparam logic [3:0] sel_pc     = 4'h0;
	localparam logic [3:0] sel_optics = 4'h1;

	// packet client registers, byte offsets in paddr[11:0]
	localparam logic [11:0] pc_ctrl  = 12'h000; // bit 0 run, self clearing
	localparam logic [11:0] pc_len   = 12'h004; // bytes per packet
	localparam logic [11:0] pc_count = 12'h008; // packets per run
	localparam logic [11:0] pc_sent  = 12'h00c; // read only

	// optics registers
	localparam logic [11:0] opt_ctrl   = 12'h000;
	localparam logic [11:0] opt_status = 12'h004; // live, after sync
	localparam logic [11:0] opt_sticky = 12'h008; // write 1 to clear

	////////////////////////////////////////
	// cfp control register layout
	////////////////////////////////////////

	localparam int ctl_w        = 11;
	localparam int ctl_lopwr    = 0;
	localparam int ctl_mod_rst  = 1;  // pin is active low
	localparam int ctl_tx_dis   = 2;
	localparam int ctl_prg_cntl = 3;  // 3 bits, prg_cntl[3:1]
	localparam int ctl_prtadr   = 6;  // 5 bits

	// low power and tx disabled until software says otherwise
	localparam logic [31:0] opt_ctrl_rst = 32'h0000_0005;

	// status and sticky layout
	// bit 0 mod_abs, 1 rx_los, 2 glb_alrm, 5:3 prg_alrm[3:1]
	localparam int st_w = 6;
	localparam logic [5:0] alarm_mask = 6'b111110; // mod_abs never latches

endpackage
